// File: rtl/dmc_pkg.sv
package dmc_pkg;

  localparam int ADDR_W = 26;
  localparam int ROW_W  = 13;
  localparam int BANK_W = 3;
  localparam int COL_W  = 10;

  typedef logic [ADDR_W-1:0] app_addr_t;
  typedef logic [ROW_W-1:0]  row_t;
  typedef logic [BANK_W-1:0] bank_t;
  typedef logic [COL_W-1:0]  col_t;
  typedef logic [15:0]       dfi_addr_t;
  typedef logic [7:0]        tick_t;      // Saturating cycle count.

  // Codes are the {cs_n, ras_n, cas_n, we_n} pin patterns.
  typedef enum logic [3:0] {
    LMR      = 4'b0000,
    REF      = 4'b0001,
    PRE      = 4'b0010,
    ACT      = 4'b0011,
    WRITE    = 4'b0100,
    READ     = 4'b0101,
    NOP      = 4'b0111,
    DESELECT = 4'b1111
  } dmc_cmd_e;

  typedef enum logic [0:0] {
    WR = 1'b0,
    RD = 1'b1
  } app_cmd_e;

  localparam int QCMD_W = $bits(dmc_cmd_e) + BANK_W + $bits(dfi_addr_t);

  localparam int T_MRD     = 2;
  localparam int T_RFC     = 12;
  localparam int T_RP      = 3;
  localparam int T_RAS     = 7;
  localparam int T_RRD     = 2;
  localparam int T_RCD     = 3;
  localparam int T_WR      = 3;
  localparam int T_WTR     = 2;
  localparam int T_RTP     = 2;
  localparam int CAS_LAT   = 3;
  localparam int BURST_LEN = 4;             // DFI beats per burst.
  localparam int T_REFI    = 400;
  localparam int INIT_WAIT = 10;

endpackage

// File: rtl/dmc_cmd_seq.sv
`timescale 1ns/10ps

module dmc_cmd_seq (
  input  logic                       dfi_clk_i,
  input  logic                       dfi_clk_sync_rst_i,
  input  logic                       app_en_i,
  input  dmc_pkg::app_cmd_e          app_cmd_i,
  input  dmc_pkg::app_addr_t         app_addr_i,
  output logic                       app_rdy_o,
  input  logic                       q_ready_i,
  output logic                       seq_push_o,
  output logic [dmc_pkg::QCMD_W-1:0] seq_cmd_o,
  output logic                       init_done_o,
  output logic                       refresh_in_progress_o
);
  import dmc_pkg::*;

  typedef enum logic [1:0] {IDLE, INIT, REFR, LDST} seq_state_e;

  seq_state_e                state;
  logic [2:0]                step;
  logic [3:0]                wait_cnt;
  logic [3:0]                init_gap;
  logic [$clog2(T_REFI)-1:0] refi_cnt;
  logic                      refr_req;

  app_cmd_e                  req_cmd;
  row_t                      req_row;
  bank_t                     req_bank;
  col_t                      req_col;

  logic [2**BANK_W-1:0]      open_bank;
  row_t                      open_row [2**BANK_W];

  row_t                      in_row;
  bank_t                     in_bank;
  logic                      accept;

  logic                      want;
  dmc_cmd_e                  cmd_code;
  bank_t                     cmd_bank;
  dfi_addr_t                 cmd_addr;

  assign in_bank               = app_addr_i[COL_W +: BANK_W];
  assign in_row                = app_addr_i[ADDR_W-1 -: ROW_W];
  assign app_rdy_o             = (state == IDLE) && init_done_o && !refr_req;
  assign accept                = app_en_i && app_rdy_o;
  assign refresh_in_progress_o = (state == REFR);

  always_comb begin
    want     = 1'b0;
    cmd_code = NOP;
    cmd_bank = '0;
    cmd_addr = '0;
    init_gap = 4'(T_MRD - 1);
    case (state)
      INIT: begin
        want = (wait_cnt == 0) && (step < 3'd5);
        case (step)
          3'd0: begin
            cmd_code = PRE;
            cmd_addr = 16'h0400;                 // A10 selects all banks.
            init_gap = 4'(T_RP - 1);
          end
          3'd1, 3'd2: begin
            cmd_code = REF;
            init_gap = 4'(T_RFC - 1);
          end
          3'd3: begin
            cmd_code = LMR;
            cmd_addr = {8'h00, 4'(CAS_LAT), 4'($clog2(2 * BURST_LEN))};
          end
          3'd4: begin
            cmd_code = LMR;
            cmd_bank = 3'd2;                     // Extended mode register 2.
          end
          default: cmd_code = NOP;
        endcase
      end
      REFR: begin
        want     = 1'b1;
        cmd_code = (step == 3'd0) ? PRE : REF;
        cmd_addr = (step == 3'd0) ? 16'h0400 : 16'h0000;
      end
      LDST: begin
        want     = 1'b1;
        cmd_bank = req_bank;
        case (step)
          3'd0: cmd_code = PRE;
          3'd1: begin
            cmd_code = ACT;
            cmd_addr = dfi_addr_t'(req_row);
          end
          default: begin
            cmd_code = (req_cmd == RD) ? READ : WRITE;
            cmd_addr = dfi_addr_t'(req_col);
          end
        endcase
      end
      default: want = 1'b0;
    endcase
  end

  assign seq_push_o = want && q_ready_i;
  assign seq_cmd_o  = {cmd_code, cmd_bank, cmd_addr};

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      state       <= INIT;
      step        <= '0;
      wait_cnt    <= 4'(INIT_WAIT);
      init_done_o <= 1'b0;
    end else begin
      if (wait_cnt != 0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
      case (state)
        IDLE: begin
          if (refr_req) begin
            state <= REFR;
            step  <= (|open_bank) ? 3'd0 : 3'd1;   // Skip PRE when all banks are closed.
          end else if (accept) begin
            state <= LDST;
            if (!open_bank[in_bank]) begin
              step <= 3'd1;
            end else if (open_row[in_bank] == in_row) begin
              step <= 3'd2;
            end else begin
              step <= 3'd0;
            end
          end
        end
        INIT: begin
          if (seq_push_o) begin
            step     <= step + 1'b1;
            wait_cnt <= init_gap;                 // Pace init so the queue stays drained.
          end else if (step == 3'd5 && wait_cnt == 0) begin
            state       <= IDLE;
            init_done_o <= 1'b1;
          end
        end
        REFR, LDST: begin
          if (seq_push_o) begin
            step <= step + 1'b1;
            if (step == 3'd2 || (state == REFR && step == 3'd1)) begin
              state <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (accept) begin
      req_cmd  <= app_cmd_i;
      req_row  <= in_row;
      req_bank <= in_bank;
      req_col  <= app_addr_i[COL_W-1:0];
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      refi_cnt <= '0;
      refr_req <= 1'b0;
    end else if (init_done_o) begin
      if (refi_cnt == T_REFI - 1) begin
        refi_cnt <= '0;
        refr_req <= 1'b1;
      end else begin
        refi_cnt <= refi_cnt + 1'b1;
      end
      if (seq_push_o && cmd_code == REF) begin
        refr_req <= 1'b0;
      end
    end
  end

  // Bank table follows the pushed commands.
  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      open_bank <= '0;
    end else if (seq_push_o) begin
      case (cmd_code)
        ACT: open_bank[cmd_bank] <= 1'b1;
        PRE: begin
          if (cmd_addr[10]) begin
            open_bank <= '0;
          end else begin
            open_bank[cmd_bank] <= 1'b0;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (seq_push_o && cmd_code == ACT) begin
      open_row[cmd_bank] <= req_row;
    end
  end

endmodule

// File: rtl/dmc_cmd_queue.sv
`timescale 1ns/10ps

module dmc_cmd_queue (
  input  logic                       dfi_clk_i,
  input  logic                       dfi_clk_sync_rst_i,
  input  logic                       push_i,
  input  logic [dmc_pkg::QCMD_W-1:0] cmd_i,
  output logic                       ready_o,
  output logic                       valid_o,
  output logic [dmc_pkg::QCMD_W-1:0] cmd_o,
  input  logic                       pop_i
);
  import dmc_pkg::*;

  logic [QCMD_W-1:0] mem [4];
  logic [1:0]        wr_ptr;
  logic [1:0]        rd_ptr;
  logic [2:0]        count;
  logic              do_push;
  logic              do_pop;

  assign ready_o = (count != 3'd4);
  assign valid_o = (count != 3'd0);
  assign cmd_o   = mem[rd_ptr];              // Head is registered with no fall-through.

  assign do_push = push_i && ready_o;
  assign do_pop  = pop_i && valid_o;

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + 3'(do_push) - 3'(do_pop);
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= cmd_i;
    end
  end

endmodule

// File: rtl/dmc_timing_gate.sv
`timescale 1ns/10ps

module dmc_timing_gate (
  input  logic                       dfi_clk_i,
  input  logic                       dfi_clk_sync_rst_i,
  input  logic                       q_valid_i,
  input  logic [dmc_pkg::QCMD_W-1:0] q_cmd_i,
  output logic                       issue_o
);
  import dmc_pkg::*;

  dmc_cmd_e n_cmd;
  dmc_cmd_e last_cmd;
  tick_t    cmd_tick;
  tick_t    act_tick;
  tick_t    wr_tick;
  tick_t    rd_tick;
  logic     spacing_ok;

  function automatic tick_t next_tick(tick_t tick, logic restart);
    if (restart) begin
      return tick_t'(1);                     // One cycle after the issue.
    end else if (tick != '1) begin
      return tick + 1'b1;
    end
    return tick;
  endfunction

  assign n_cmd = dmc_cmd_e'(q_cmd_i[QCMD_W-1 -: $bits(dmc_cmd_e)]);

  always_comb begin
    spacing_ok = 1'b1;
    case (last_cmd)
      LMR: spacing_ok = cmd_tick >= T_MRD;
      REF: spacing_ok = cmd_tick >= T_RFC;
      PRE: begin
        spacing_ok = cmd_tick >= T_RP;
        if (n_cmd == ACT) begin
          spacing_ok = spacing_ok && (act_tick >= T_RAS);
        end
      end
      ACT: begin
        case (n_cmd)
          PRE:     spacing_ok = cmd_tick >= T_RAS;
          ACT:     spacing_ok = cmd_tick >= T_RRD;
          WRITE:   spacing_ok = (cmd_tick >= T_RCD) && (rd_tick >= CAS_LAT + BURST_LEN);
          READ:    spacing_ok = (cmd_tick >= T_RCD) && (wr_tick >= T_WTR);
          default: spacing_ok = 1'b1;
        endcase
      end
      WRITE: begin
        case (n_cmd)
          PRE:     spacing_ok = (cmd_tick >= T_WR) && (act_tick >= T_RAS);
          WRITE:   spacing_ok = cmd_tick >= BURST_LEN;
          READ:    spacing_ok = cmd_tick >= T_WTR;
          ACT:     spacing_ok = (cmd_tick >= T_RRD) && (act_tick >= T_RRD);
          default: spacing_ok = 1'b1;
        endcase
      end
      READ: begin
        case (n_cmd)
          PRE:     spacing_ok = (cmd_tick >= T_RTP) && (act_tick >= T_RAS);
          WRITE:   spacing_ok = cmd_tick >= CAS_LAT + BURST_LEN;  // Keep bursts apart on the bus.
          READ:    spacing_ok = cmd_tick >= BURST_LEN;
          ACT:     spacing_ok = (cmd_tick >= T_RRD) && (act_tick >= T_RRD);
          default: spacing_ok = 1'b1;
        endcase
      end
      default: spacing_ok = 1'b1;
    endcase
  end

  assign issue_o = q_valid_i && spacing_ok;

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      cmd_tick <= '1;
      act_tick <= '1;
      wr_tick  <= '1;
      rd_tick  <= '1;
      last_cmd <= NOP;
    end else begin
      cmd_tick <= next_tick(cmd_tick, issue_o);
      act_tick <= next_tick(act_tick, issue_o && n_cmd == ACT);
      wr_tick  <= next_tick(wr_tick, issue_o && n_cmd == WRITE);
      rd_tick  <= next_tick(rd_tick, issue_o && n_cmd == READ);
      if (issue_o) begin
        last_cmd <= n_cmd;
      end
    end
  end

endmodule

// File: rtl/dmc_dfi_drive.sv
`timescale 1ns/10ps

module dmc_dfi_drive (
  input  logic                       dfi_clk_i,
  input  logic                       dfi_clk_sync_rst_i,
  input  logic                       issue_i,
  input  logic [dmc_pkg::QCMD_W-1:0] cmd_i,
  output dmc_pkg::bank_t             dfi_bank_o,
  output dmc_pkg::dfi_addr_t         dfi_address_o,
  output logic                       dfi_cke_o,
  output logic                       dfi_cs_n_o,
  output logic                       dfi_ras_n_o,
  output logic                       dfi_cas_n_o,
  output logic                       dfi_we_n_o,
  output logic                       dfi_wrdata_en_o,
  output logic                       dfi_rddata_en_o
);
  import dmc_pkg::*;

  dmc_cmd_e                     head_cmd;
  logic                         pin_write;
  logic [$clog2(CAS_LAT)-1:0]   cas_cnt;
  logic                         cas_pend;
  logic [$clog2(BURST_LEN)-1:0] rd_cnt;
  logic [$clog2(BURST_LEN)-1:0] wr_cnt;

  assign head_cmd  = dmc_cmd_e'(cmd_i[QCMD_W-1 -: $bits(dmc_cmd_e)]);
  assign pin_write = ({dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} == WRITE);

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} <= DESELECT;
      dfi_bank_o    <= '0;
      dfi_address_o <= '0;
    end else if (issue_i) begin
      {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} <= head_cmd;
      dfi_bank_o    <= cmd_i[$bits(dfi_addr_t) +: BANK_W];
      dfi_address_o <= cmd_i[$bits(dfi_addr_t)-1:0];
    end else begin
      {dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o} <= DESELECT;  // One cycle per command.
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      dfi_cke_o <= 1'b0;
    end else begin
      dfi_cke_o <= 1'b1;
    end
  end

  // Write window opens the cycle after the WRITE is on the pins.
  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      wr_cnt          <= '0;
      dfi_wrdata_en_o <= 1'b0;
    end else if (pin_write) begin
      wr_cnt          <= ($clog2(BURST_LEN))'(BURST_LEN - 1);
      dfi_wrdata_en_o <= 1'b1;
    end else if (dfi_wrdata_en_o) begin
      wr_cnt <= wr_cnt - 1'b1;
      if (wr_cnt == 0) begin
        dfi_wrdata_en_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      cas_cnt  <= '0;
      cas_pend <= 1'b0;
    end else if (issue_i && head_cmd == READ) begin
      cas_cnt  <= ($clog2(CAS_LAT))'(CAS_LAT - 1);
      cas_pend <= 1'b1;
    end else if (cas_pend) begin
      cas_cnt <= cas_cnt - 1'b1;
      if (cas_cnt == 0) begin
        cas_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge dfi_clk_i) begin
    if (dfi_clk_sync_rst_i) begin
      rd_cnt          <= '0;
      dfi_rddata_en_o <= 1'b0;
    end else if (cas_pend && cas_cnt == 0) begin
      rd_cnt          <= ($clog2(BURST_LEN))'(BURST_LEN - 1);
      dfi_rddata_en_o <= 1'b1;
    end else if (dfi_rddata_en_o) begin
      rd_cnt <= rd_cnt - 1'b1;
      if (rd_cnt == 0) begin
        dfi_rddata_en_o <= 1'b0;
      end
    end
  end

endmodule

// File: rtl/dmc_top.sv
`timescale 1ns/10ps

module dmc_top (
  input  logic               dfi_clk_i,
  input  logic               dfi_clk_sync_rst_i,
  input  logic               app_en_i,
  input  dmc_pkg::app_cmd_e  app_cmd_i,
  input  dmc_pkg::app_addr_t app_addr_i,
  output logic               app_rdy_o,
  output logic               init_done_o,
  output logic               refresh_in_progress_o,
  output dmc_pkg::bank_t     dfi_bank_o,
  output dmc_pkg::dfi_addr_t dfi_address_o,
  output logic               dfi_cke_o,
  output logic               dfi_cs_n_o,
  output logic               dfi_ras_n_o,
  output logic               dfi_cas_n_o,
  output logic               dfi_we_n_o,
  output logic               dfi_wrdata_en_o,
  output logic               dfi_rddata_en_o
);
  import dmc_pkg::*;

  logic              q_ready;
  logic              seq_push;
  logic [QCMD_W-1:0] seq_cmd;
  logic              q_valid;
  logic [QCMD_W-1:0] q_cmd;
  logic              issue;

  dmc_cmd_seq u_seq (
    .dfi_clk_i             (dfi_clk_i),
    .dfi_clk_sync_rst_i    (dfi_clk_sync_rst_i),
    .app_en_i              (app_en_i),
    .app_cmd_i             (app_cmd_i),
    .app_addr_i            (app_addr_i),
    .app_rdy_o             (app_rdy_o),
    .q_ready_i             (q_ready),
    .seq_push_o            (seq_push),
    .seq_cmd_o             (seq_cmd),
    .init_done_o           (init_done_o),
    .refresh_in_progress_o (refresh_in_progress_o)
  );

  dmc_cmd_queue u_queue (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .push_i             (seq_push),
    .cmd_i              (seq_cmd),
    .ready_o            (q_ready),
    .valid_o            (q_valid),
    .cmd_o              (q_cmd),
    .pop_i              (issue)
  );

  dmc_timing_gate u_gate (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .q_valid_i          (q_valid),
    .q_cmd_i            (q_cmd),
    .issue_o            (issue)
  );

  dmc_dfi_drive u_drive (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .issue_i            (issue),
    .cmd_i              (q_cmd),
    .dfi_bank_o         (dfi_bank_o),
    .dfi_address_o      (dfi_address_o),
    .dfi_cke_o          (dfi_cke_o),
    .dfi_cs_n_o         (dfi_cs_n_o),
    .dfi_ras_n_o        (dfi_ras_n_o),
    .dfi_cas_n_o        (dfi_cas_n_o),
    .dfi_we_n_o         (dfi_we_n_o),
    .dfi_wrdata_en_o    (dfi_wrdata_en_o),
    .dfi_rddata_en_o    (dfi_rddata_en_o)
  );

endmodule

// File: test/dmc_asserts.sv
`timescale 1ns/10ps

module dmc_asserts (
  input logic                       dfi_clk_i,
  input logic                       dfi_clk_sync_rst_i,
  input logic                       q_valid_i,
  input logic [dmc_pkg::QCMD_W-1:0] q_cmd_i,
  input logic                       issue_o
);
  import dmc_pkg::*;

  dmc_cmd_e head;

  assign head = dmc_cmd_e'(q_cmd_i[QCMD_W-1 -: $bits(dmc_cmd_e)]);

  issue_needs_entry: assert property (@(posedge dfi_clk_i) disable iff (dfi_clk_sync_rst_i)
    issue_o |-> q_valid_i)
    else $error("issue fired with an empty command queue");

  pre_to_act: assert property (@(posedge dfi_clk_i) disable iff (dfi_clk_sync_rst_i)
    (issue_o && head == PRE) |=> !(issue_o && head == ACT) [*T_RP-1])
    else $error("ACT issued within T_RP of PRE");

  act_to_read: assert property (@(posedge dfi_clk_i) disable iff (dfi_clk_sync_rst_i)
    (issue_o && head == ACT) |=> !(issue_o && head == READ) [*T_RCD-1])
    else $error("READ issued within T_RCD of ACT");

endmodule

// File: test/dmc_tb.sv
`timescale 1ns/10ps

module dmc_tb;
  import dmc_pkg::*;

  logic      dfi_clk_i;
  logic      dfi_clk_sync_rst_i;
  logic      app_en_i;
  app_cmd_e  app_cmd_i;
  app_addr_t app_addr_i;
  logic      app_rdy_o;
  logic      init_done_o;
  logic      refresh_in_progress_o;
  bank_t     dfi_bank_o;
  dfi_addr_t dfi_address_o;
  logic      dfi_cke_o;
  logic      dfi_cs_n_o;
  logic      dfi_ras_n_o;
  logic      dfi_cas_n_o;
  logic      dfi_we_n_o;
  logic      dfi_wrdata_en_o;
  logic      dfi_rddata_en_o;

  logic [35:0] vec_mem [64];             // {op, class, address} per request.
  int          n_vec;
  int          wd_limit;
  int          errors;
  int          tests;
  int          tests_failed;
  logic [31:0] lfsr;

  // Command log seen on the DFI pins.
  dmc_cmd_e    log_cmd [$];
  bank_t       log_bank [$];
  dfi_addr_t   log_addr [$];
  int          log_cyc [$];
  int          cyc;
  int          scan_idx;
  logic        init_seen;

  // Open-row model built from the address split.
  logic [7:0]  mopen;
  row_t        mrow [8];
  logic [7:0]  rf_closed;                // Banks closed by a refresh since last ACT.

  dmc_top uut (.*);

  bind dmc_timing_gate dmc_asserts u_asserts (
    .dfi_clk_i          (dfi_clk_i),
    .dfi_clk_sync_rst_i (dfi_clk_sync_rst_i),
    .q_valid_i          (q_valid_i),
    .q_cmd_i            (q_cmd_i),
    .issue_o            (issue_o)
  );

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int draw_bits(int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = (val << 1) | lfsr[0];
    end
    return val;
  endfunction

  function automatic int min_gap(dmc_cmd_e prev, dmc_cmd_e next);
    int gap;
    gap = 1;
    case (prev)
      LMR: gap = T_MRD;
      REF: gap = T_RFC;
      PRE: gap = T_RP;
      ACT: begin
        if (next == READ || next == WRITE) begin
          gap = T_RCD;
        end else if (next == PRE) begin
          gap = T_RAS;
        end else if (next == ACT) begin
          gap = T_RRD;
        end
      end
      WRITE: begin
        if (next == PRE) begin
          gap = T_WR;
        end else if (next == READ) begin
          gap = T_WTR;
        end
      end
      READ: begin
        if (next == PRE) begin
          gap = T_RTP;
        end
      end
      default: gap = 1;
    endcase
    return gap;
  endfunction

  initial begin
    dfi_clk_i = 1'b0;
    forever #50 dfi_clk_i = ~dfi_clk_i;
  end

  // Pin monitor logs commands and checks spacing, data windows and refresh.
  initial begin : monitor
    dmc_cmd_e   pin_cmd;
    dmc_cmd_e   prev;
    logic [7:0] pin_open;
    logic       pre_all_had_open;
    logic       prev_pre_all;
    logic       refr_seen;
    logic       had_open;
    logic       cke_exp;
    logic [15:0] rd_sched;
    logic [15:0] wr_sched;
    int         last_act;
    int         last_ref;
    int         gap;
    cyc = 0;
    pin_open = '0;
    pre_all_had_open = 1'b0;
    refr_seen = 1'b0;
    cke_exp = 1'b0;
    rd_sched = '0;
    wr_sched = '0;
    last_act = -1000;
    last_ref = 0;
    forever begin
      @(posedge dfi_clk_i);
      cyc++;
      if (!dfi_clk_sync_rst_i) begin
        check_value("cke after reset", cke_exp, dfi_cke_o);
        cke_exp = 1'b1;                  // CKE rises one cycle after reset ends.
        if (!init_done_o || refresh_in_progress_o) begin
          check_value("app_rdy while busy", 0, app_rdy_o);
        end
        check_value("rddata_en window", rd_sched[0], dfi_rddata_en_o);
        check_value("wrdata_en window", wr_sched[0], dfi_wrdata_en_o);
        rd_sched = rd_sched >> 1;
        wr_sched = wr_sched >> 1;
        if (refresh_in_progress_o) begin
          refr_seen = 1'b1;
        end
        pin_cmd = dmc_cmd_e'({dfi_cs_n_o, dfi_ras_n_o, dfi_cas_n_o, dfi_we_n_o});
        if (pin_cmd != DESELECT) begin
          prev_pre_all = 1'b0;
          if (log_cmd.size() > 0) begin
            prev = log_cmd[$];
            prev_pre_all = (prev == PRE) && log_addr[$][10];
            gap = cyc - log_cyc[$];
            if (gap < min_gap(prev, pin_cmd)) begin
              check_value($sformatf("spacing %s->%s", prev.name(), pin_cmd.name()),
                          min_gap(prev, pin_cmd), gap);
            end
          end
          case (pin_cmd)
            ACT: begin
              pin_open[dfi_bank_o] = 1'b1;
              last_act = cyc;
            end
            PRE: begin
              if (cyc - last_act < T_RAS) begin
                check_value("spacing ACT->PRE (tRAS)", T_RAS, cyc - last_act);
              end
              if (dfi_address_o[10]) begin
                pre_all_had_open = |pin_open;
                pin_open = '0;
              end else begin
                pin_open[dfi_bank_o] = 1'b0;
              end
            end
            READ: rd_sched = rd_sched | (16'((1 << BURST_LEN) - 1) << (CAS_LAT - 1));
            WRITE: wr_sched = wr_sched | 16'((1 << BURST_LEN) - 1);
            REF: begin
              if (init_seen) begin
                check_value("refresh_in_progress before REF", 1, refr_seen);
                refr_seen = 1'b0;
                if (cyc - last_ref > T_REFI + 60) begin
                  check_value("refresh interval", T_REFI + 60, cyc - last_ref);
                end
                had_open = prev_pre_all ? pre_all_had_open : |pin_open;
                check_value("PRE-all before REF", had_open, prev_pre_all);
              end
              last_ref = cyc;
            end
            default: ;
          endcase
          log_cmd.push_back(pin_cmd);
          log_bank.push_back(dfi_bank_o);
          log_addr.push_back(dfi_address_o);
          log_cyc.push_back(cyc);
        end
        if (init_done_o && !init_seen) begin
          init_seen = 1'b1;
          check_value("commands before init_done", 5, log_cmd.size());
        end
      end
    end
  end

  task automatic run_request(input int idx);
    logic [35:0] v;
    app_cmd_e    op;
    logic [3:0]  vclass;
    app_addr_t   addr;
    row_t        row;
    bank_t       bank;
    col_t        col;
    int          start_err;
    int          found;
    int          mclass;
    int          fclass;
    int          n;
    logic        first;
    dmc_cmd_e    rcmd [$];
    bank_t       rbank [$];
    dfi_addr_t   raddr [$];
    string       name;
    v         = vec_mem[idx];
    op        = app_cmd_e'(v[32]);
    vclass    = v[31:28];
    addr      = v[ADDR_W-1:0];
    row       = addr[25:13];
    bank      = addr[12:10];
    col       = addr[9:0];
    start_err = errors;
    name      = $sformatf("req%0d", idx);
    mclass    = -1;
    first     = 1'b1;
    repeat (draw_bits(6) + 1) @(posedge dfi_clk_i);
    #10;
    app_en_i   = 1'b1;
    app_cmd_i  = op;
    app_addr_i = addr;
    forever begin
      @(posedge dfi_clk_i);
      if (app_rdy_o) begin
        break;
      end
    end
    #10;
    app_en_i = 1'b0;
    found = -1;
    while (found < 0) begin
      @(posedge dfi_clk_i);
      #1;
      for (int p = scan_idx; p < log_cmd.size(); p++) begin
        if (found < 0 && (log_cmd[p] == READ || log_cmd[p] == WRITE)) begin
          found = p;
        end
      end
    end
    for (int p = scan_idx; p <= found; p++) begin
      if (log_cmd[p] == PRE && log_addr[p][10]) begin
        rf_closed = rf_closed | mopen;
        mopen = '0;
      end else if (log_cmd[p] != REF) begin
        if (first) begin
          first = 1'b0;
          if (!mopen[bank]) begin
            mclass = 1;
          end else if (mrow[bank] == row) begin
            mclass = 0;
          end else begin
            mclass = 2;
          end
        end
        rcmd.push_back(log_cmd[p]);
        rbank.push_back(log_bank[p]);
        raddr.push_back(log_addr[p]);
      end
    end
    n = rcmd.size();
    if (n < 1 || n > 3) begin
      errors++;
      $display("%s produced %0d commands, which fits no access sequence", name, n);
    end else begin
      fclass = (n == 1) ? 0 : ((n == 2) ? 1 : 2);
      check_value({name, " class vs vectors"}, rf_closed[bank] ? 1 : vclass, fclass);
      check_value({name, " class vs model"}, mclass, fclass);
      check_value({name, " command"}, (op == RD) ? READ : WRITE, rcmd[n-1]);
      check_value({name, " command bank"}, bank, rbank[n-1]);
      check_value({name, " column"}, col, raddr[n-1]);
      if (n >= 2) begin
        check_value({name, " ACT"}, ACT, rcmd[n-2]);
        check_value({name, " ACT bank"}, bank, rbank[n-2]);
        check_value({name, " ACT row"}, row, raddr[n-2]);
      end
      if (n == 3) begin
        check_value({name, " PRE"}, PRE, rcmd[0]);
        check_value({name, " PRE bank"}, bank, rbank[0]);
      end
    end
    mopen[bank]     = 1'b1;
    mrow[bank]      = row;
    rf_closed[bank] = 1'b0;
    scan_idx        = found + 1;
    tests++;
    if (errors != start_err) begin
      tests_failed++;
    end
    $display("%s %s: %s", name, op.name(), (errors == start_err) ? "pass" : "FAIL");
  endtask

  initial begin
    wait (wd_limit > 0);
    repeat (wd_limit) @(posedge dfi_clk_i);
    $display("Timeout: the run did not finish within %0d cycles", wd_limit);
    $display("Errors found");
    $finish;
  end

  initial begin : main
    int start_err;
    dfi_clk_sync_rst_i = 1'b1;
    app_en_i     = 1'b0;
    app_cmd_i    = RD;
    app_addr_i   = '0;
    errors       = 0;
    tests        = 0;
    tests_failed = 0;
    lfsr         = 32'h4389_4f1b;
    init_seen    = 1'b0;
    scan_idx     = 0;
    mopen        = '0;
    rf_closed    = '0;
    wd_limit     = 0;
    n_vec        = 0;
    $readmemh("test/dmc_vectors.txt", vec_mem);
    while (n_vec < 64 && !$isunknown(vec_mem[n_vec])) begin
      n_vec++;
    end
    if (n_vec == 0) begin
      errors++;
      $display("No request vectors could be read from the vector file");
    end
    wd_limit = n_vec * 60 + 2000;
    repeat (8) @(posedge dfi_clk_i);
    #10;
    dfi_clk_sync_rst_i = 1'b0;
    start_err = errors;
    while (!init_seen) begin
      @(posedge dfi_clk_i);
    end
    #1;
    if (log_cmd.size() >= 5) begin
      check_value("init cmd 0", PRE, log_cmd[0]);
      check_value("init PRE A10", 1, log_addr[0][10]);
      check_value("init cmd 1", REF, log_cmd[1]);
      check_value("init cmd 2", REF, log_cmd[2]);
      check_value("init cmd 3", LMR, log_cmd[3]);
      check_value("init cmd 4", LMR, log_cmd[4]);
    end
    scan_idx = log_cmd.size();
    tests++;
    if (errors != start_err) begin
      tests_failed++;
    end
    $display("init: %s", (errors == start_err) ? "pass" : "FAIL");
    for (int i = 0; i < n_vec; i++) begin
      run_request(i);
    end
    repeat (20) @(posedge dfi_clk_i);      // Let the last burst window close.
    $display("Tests: %0d, failed: %0d, errors: %0d", tests, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: test/dmc_vectors.txt
// Hex digits: [8] op (0 write, 1 read), [7] class (0 hit, 1 closed, 2 miss),
// [6:0] address = row[25:13] bank[12:10] column[9:0]
110002010
000002020
120004030
01000AC44
10000AFFF
000004001
113FFFD55
023FFDEAA
120006C08
100006C09
010200400
000200480
103FFDC00
120002400
000004002
010013405

// File: compile.f
rtl/dmc_pkg.sv
rtl/dmc_cmd_seq.sv
rtl/dmc_cmd_queue.sv
rtl/dmc_timing_gate.sv
rtl/dmc_dfi_drive.sv
rtl/dmc_top.sv
test/dmc_asserts.sv
test/dmc_tb.sv

// File: Bender.yml
package:
  name: dmc

sources:
  - rtl/dmc_pkg.sv
  - rtl/dmc_cmd_seq.sv
  - rtl/dmc_cmd_queue.sv
  - rtl/dmc_timing_gate.sv
  - rtl/dmc_dfi_drive.sv
  - rtl/dmc_top.sv
  - target: test
    files:
      - test/dmc_asserts.sv
      - test/dmc_tb.sv
